//--- csi2_pkg.sv
package csi2_pkg;

typedef logic [31 : 0] word_t;
typedef logic [1 : 0]  vc_t;
typedef logic [5 : 0]  dt_t;
typedef logic [15 : 0] wc_t;
typedef logic [3 : 0]  be_t;
typedef logic [15 : 0] frame_num_t;
typedef logic [15 : 0] crc_t;

typedef enum logic [1 : 0]
{
  ENTRY_SHORT,
  ENTRY_LONG_HDR,
  ENTRY_PAYLOAD,
  ENTRY_ABORT
} entry_kind_e;

typedef struct packed
{
  logic  valid;
  word_t data;          // Header words carry the ECC in bits 29 to 24.
} lane_word_t;

typedef struct packed
{
  logic  valid;
  word_t data;
  logic  corrected;
  logic  uncorrectable;
} hdr_word_t;

typedef struct packed
{
  entry_kind_e kind;
  vc_t         vc;
  dt_t         dt;
  wc_t         field;   // Word count plus 2 for long packets, data field for short ones.
  word_t       data;
  be_t         be;
  logic        eop;
} pkt_entry_t;

typedef struct packed
{
  vc_t        vc;
  dt_t        dt;
  frame_num_t frame_num;
  wc_t        word_cnt;
  crc_t       crc_rx;
  crc_t       crc_calc;
  logic       crc_ok;
  logic       aborted;
} line_report_t;

localparam dt_t DT_FRAME_START = 6'h00;
localparam dt_t DT_FRAME_END   = 6'h01;
localparam dt_t DT_SHORT_MAX   = 6'h0f;

endpackage

//--- csi2_header_ecc.sv
`timescale 1ns/1ps

module csi2_header_ecc
(
  input                        clk_i,
  input                        rst_i,
  input  csi2_pkg::lane_word_t lane_i,
  output csi2_pkg::hdr_word_t  hdr_o
);

import csi2_pkg::*;

// Syndrome column per header bit: D0 to D23, then P0 to P5.
localparam logic [5 : 0] ECC_COL [30] = '{
  6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
  6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
  6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b,
  6'h01, 6'h02, 6'h04, 6'h08, 6'h10, 6'h20
};

logic         valid_d1;
logic         is_header;
logic [5 : 0] parity;
logic [5 : 0] syndrome;
word_t        fixed;
logic         hit;

assign is_header = lane_i.valid && !valid_d1; // First valid word after idle.

always_comb
  begin
    parity = 6'd0;
    for (int i = 0; i < 24; i++)
      if (lane_i.data[i])
        parity = parity ^ ECC_COL[i];
  end

assign syndrome = parity ^ lane_i.data[29 : 24];

always_comb
  begin
    fixed = lane_i.data;
    hit   = 1'b0;
    for (int i = 0; i < 30; i++)
      if (syndrome == ECC_COL[i])
        begin
          fixed[i] = ~lane_i.data[i];
          hit      = 1'b1;
        end
  end

always_ff @(posedge clk_i)
  if (rst_i)
    begin
      valid_d1            <= 1'b0;
      hdr_o.valid         <= 1'b0;
      hdr_o.corrected     <= 1'b0;
      hdr_o.uncorrectable <= 1'b0;
    end
  else
    begin
      valid_d1            <= lane_i.valid;
      hdr_o.valid         <= lane_i.valid;
      hdr_o.data          <= is_header ? fixed : lane_i.data;
      hdr_o.corrected     <= is_header && hit;
      hdr_o.uncorrectable <= is_header && (syndrome != 6'd0) && !hit;
    end

assert property (@(posedge clk_i) disable iff (rst_i)
  !(hdr_o.corrected && hdr_o.uncorrectable));

endmodule

//--- csi2_pkt_handler.sv
`timescale 1ns/1ps

module csi2_pkt_handler
(
  input                        clk_i,
  input                        rst_i,
  input  csi2_pkg::hdr_word_t  hdr_i,
  output csi2_pkg::pkt_entry_t entry_o,
  output logic                 push_o
);

import csi2_pkg::*;

logic       valid_d1;
logic       hdr_edge;
logic       hdr_ok;
logic       abort;
logic       short_pkt;
logic       long_pkt;
logic       payload;
logic       pkt_running;
logic       last_word;
logic       pkt_done;
wc_t        byte_cnt;
wc_t        long_field;
vc_t        long_vc;
dt_t        long_dt;
be_t        be_last;
pkt_entry_t entry_d;
logic       push_d;

assign hdr_edge  = hdr_i.valid && !valid_d1;
assign abort     = hdr_edge && hdr_i.uncorrectable;
assign hdr_ok    = hdr_edge && !hdr_i.uncorrectable && !pkt_running;
assign short_pkt = hdr_ok && (hdr_i.data[5 : 0] <= DT_SHORT_MAX);
assign long_pkt  = hdr_ok && (hdr_i.data[5 : 0] > DT_SHORT_MAX);
assign payload   = hdr_i.valid && pkt_running && !abort;
assign last_word = (byte_cnt + 16'd4) >= long_field;
assign pkt_done  = (payload && last_word) || abort;

always_ff @(posedge clk_i)
  if (rst_i)
    valid_d1 <= 1'b0;
  else
    valid_d1 <= hdr_i.valid;

always_ff @(posedge clk_i)
  if (rst_i)
    pkt_running <= 1'b0;
  else
    if (long_pkt)
      pkt_running <= 1'b1;
    else
      if (pkt_done)
        pkt_running <= 1'b0;

always_ff @(posedge clk_i)
  if (rst_i)
    byte_cnt <= 16'd0;
  else
    if (long_pkt || pkt_done)
      byte_cnt <= 16'd0;
    else
      if (payload)
        byte_cnt <= byte_cnt + 16'd4;

always_ff @(posedge clk_i)
  if (long_pkt)
    begin
      long_vc    <= hdr_i.data[7 : 6];
      long_dt    <= hdr_i.data[5 : 0];
      long_field <= hdr_i.data[23 : 8] + 16'd2; // Payload plus the two CRC bytes.
    end

always_comb
  begin
    for (int i = 0; i < 4; i++)
      be_last[i] = long_field[1 : 0] > 2'(i);
    if (be_last == 4'd0)
      be_last = 4'b1111;                        // Length is a multiple of 4.
  end

always_comb
  begin
    entry_d       = '0;
    entry_d.vc    = hdr_i.data[7 : 6];
    entry_d.dt    = hdr_i.data[5 : 0];
    entry_d.field = hdr_i.data[23 : 8];
    push_d        = 1'b1;
    if (abort)
      begin
        entry_d.kind = ENTRY_ABORT;
        entry_d.eop  = 1'b1;
      end
    else if (short_pkt)
      entry_d.kind = ENTRY_SHORT;
    else if (long_pkt)
      begin
        entry_d.kind  = ENTRY_LONG_HDR;
        entry_d.field = hdr_i.data[23 : 8] + 16'd2;
      end
    else
      begin
        entry_d.kind  = ENTRY_PAYLOAD;
        entry_d.vc    = long_vc;
        entry_d.dt    = long_dt;
        entry_d.field = long_field;
        entry_d.data  = hdr_i.data;
        entry_d.be    = last_word ? be_last : 4'b1111;
        entry_d.eop   = last_word;
        push_d        = payload;
      end
  end

always_ff @(posedge clk_i)
  if (rst_i)
    push_o <= 1'b0;
  else
    push_o <= push_d;

always_ff @(posedge clk_i)
  entry_o <= entry_d;

assert property (@(posedge clk_i) disable iff (rst_i)
  push_o && entry_o.kind == ENTRY_PAYLOAD |-> $past(pkt_running));

endmodule

//--- csi2_payload_fifo.sv
`timescale 1ns/1ps

module csi2_payload_fifo
#(
  parameter int FIFO_DEPTH = 16,
  parameter int CREDITS    = 2
)
(
  input                        clk_i,
  input                        rst_i,
  input                        push_i,
  input  csi2_pkg::pkt_entry_t entry_i,
  output logic                 send_o,
  output csi2_pkg::pkt_entry_t entry_o,
  input                        credit_i,
  output logic                 overflow_o
);

import csi2_pkg::*;

localparam int AW = $clog2(FIFO_DEPTH);
localparam int CW = $clog2(CREDITS + 1);

pkt_entry_t      mem [FIFO_DEPTH];
logic [AW-1 : 0] wr_ptr;
logic [AW-1 : 0] rd_ptr;
logic [AW : 0]   count;
logic [CW-1 : 0] credit_cnt;
logic            full;
logic            empty;
logic            wr_en;
logic            rd_en;

assign full  = count == (AW+1)'(FIFO_DEPTH);
assign empty = count == '0;
assign wr_en = push_i && !full;                 // A push into a full buffer is lost.
assign rd_en = !empty && (credit_cnt != '0);

always_ff @(posedge clk_i)
  if (wr_en)
    mem[wr_ptr] <= entry_i;

always_ff @(posedge clk_i)
  if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
  else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
    end

always_ff @(posedge clk_i)
  if (rst_i)
    credit_cnt <= CW'(CREDITS);
  else
    credit_cnt <= credit_cnt + CW'(credit_i) - CW'(rd_en);

always_ff @(posedge clk_i)
  if (rst_i)
    send_o <= 1'b0;
  else
    send_o <= rd_en;

always_ff @(posedge clk_i)
  entry_o <= mem[rd_ptr];

always_ff @(posedge clk_i)
  if (rst_i)
    overflow_o <= 1'b0;
  else
    if (push_i && full)
      overflow_o <= 1'b1;                       // Sticky until reset.

assert property (@(posedge clk_i) disable iff (rst_i)
  credit_cnt <= CW'(CREDITS));

assert property (@(posedge clk_i) disable iff (rst_i)
  send_o |-> $past(credit_cnt) != '0);

endmodule

//--- csi2_line_checker.sv
`timescale 1ns/1ps

module csi2_line_checker
#(
  parameter int CREDITS = 2
)
(
  input                          clk_i,
  input                          rst_i,
  input                          send_i,
  input  csi2_pkg::pkt_entry_t   entry_i,
  output logic                   credit_o,
  output csi2_pkg::line_report_t report_o,
  output logic                   report_valid_o,
  input                          report_ready_i,
  output csi2_pkg::frame_num_t   frame_num_o,
  output logic                   in_frame_o
);

import csi2_pkg::*;

localparam int QW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
localparam int CW = $clog2(CREDITS + 1);

typedef enum logic [1 : 0] { IDLE, PAYLOAD, REPORT } state_e;

state_e          state;
pkt_entry_t      queue [CREDITS];
logic [QW-1 : 0] q_wr;
logic [QW-1 : 0] q_rd;
logic [CW-1 : 0] q_cnt;
pkt_entry_t      head;
logic            head_valid;
logic            bypass;
logic            pop;
logic            q_push;
vc_t             cur_vc;
dt_t             cur_dt;
wc_t             data_len;
wc_t             byte_cnt;
crc_t            crc_q;
crc_t            crc_rx_q;
crc_t            crc_next;
crc_t            crc_rx_next;
line_report_t    rep_next;

// Reflected CRC-16, polynomial x^16+x^12+x^5+1.
function automatic crc_t crc_byte(crc_t crc, logic [7 : 0] b);
  crc_t r;
  r = crc ^ {8'h00, b};
  for (int k = 0; k < 8; k++)
    r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
  return r;
endfunction

function automatic logic [QW-1 : 0] q_inc(logic [QW-1 : 0] p);
  return (p == QW'(CREDITS - 1)) ? '0 : p + 1'b1;
endfunction

assign bypass         = q_cnt == '0;    // An empty queue hands the arriving entry straight on.
assign head           = bypass ? entry_i : queue[q_rd];
assign head_valid     = send_i || !bypass;
assign pop            = head_valid && (state != REPORT);
assign q_push         = send_i && !(pop && bypass);
assign report_valid_o = state == REPORT;

always_ff @(posedge clk_i)
  if (q_push)
    queue[q_wr] <= entry_i;

always_ff @(posedge clk_i)
  if (rst_i)
    begin
      q_wr     <= '0;
      q_rd     <= '0;
      q_cnt    <= '0;
      credit_o <= 1'b0;
    end
  else
    begin
      credit_o <= pop;
      if (q_push)
        q_wr <= q_inc(q_wr);
      if (pop && !bypass)
        q_rd <= q_inc(q_rd);
      q_cnt <= q_cnt + CW'(q_push) - CW'(pop && !bypass);
    end

always_comb
  begin : crc_calc
    wc_t idx;
    crc_next    = crc_q;
    crc_rx_next = crc_rx_q;
    for (int j = 0; j < 4; j++)
      begin
        idx = byte_cnt + wc_t'(j);
        if (head.be[j])
          begin
            if (idx < data_len)
              crc_next = crc_byte(crc_next, head.data[8*j +: 8]);
            else if (idx == data_len)
              crc_rx_next[7 : 0] = head.data[8*j +: 8];   // Footer is sent low byte first.
            else
              crc_rx_next[15 : 8] = head.data[8*j +: 8];
          end
      end
  end

always_comb
  begin
    rep_next.frame_num = frame_num_o;
    if (head.kind == ENTRY_ABORT)
      begin
        rep_next.vc       = head.vc;
        rep_next.dt       = head.dt;
        rep_next.word_cnt = head.field;
        rep_next.crc_rx   = '0;
        rep_next.crc_calc = '0;
        rep_next.crc_ok   = 1'b0;
        rep_next.aborted  = 1'b1;
      end
    else
      begin
        rep_next.vc       = cur_vc;
        rep_next.dt       = cur_dt;
        rep_next.word_cnt = data_len;
        rep_next.crc_rx   = crc_rx_next;
        rep_next.crc_calc = crc_next;
        rep_next.crc_ok   = crc_rx_next == crc_next;
        rep_next.aborted  = 1'b0;
      end
  end

always_ff @(posedge clk_i)
  if (rst_i)
    begin
      state       <= IDLE;
      frame_num_o <= '0;
      in_frame_o  <= 1'b0;
    end
  else
    begin
      if (pop && head.kind == ENTRY_SHORT)
        begin
          if (head.dt == DT_FRAME_START)
            begin
              frame_num_o <= head.field;
              in_frame_o  <= 1'b1;
            end
          else if (head.dt == DT_FRAME_END)
            in_frame_o <= 1'b0;
        end
      case (state)
        IDLE:
          if (pop && head.kind == ENTRY_LONG_HDR)
            begin
              cur_vc   <= head.vc;
              cur_dt   <= head.dt;
              data_len <= head.field - 16'd2;
              byte_cnt <= '0;
              crc_q    <= 16'hffff;
              crc_rx_q <= '0;
              state    <= PAYLOAD;
            end
          else if (pop && head.kind == ENTRY_ABORT)
            begin
              report_o <= rep_next;
              state    <= REPORT;
            end
        PAYLOAD:
          if (pop && head.kind == ENTRY_PAYLOAD)
            begin
              crc_q    <= crc_next;
              crc_rx_q <= crc_rx_next;
              byte_cnt <= byte_cnt + 16'd4;
              if (head.eop)
                begin
                  report_o <= rep_next;
                  state    <= REPORT;
                end
            end
          else if (pop && head.kind == ENTRY_ABORT)
            begin
              report_o <= rep_next;
              state    <= REPORT;
            end
        REPORT:
          if (report_ready_i)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end

assert property (@(posedge clk_i) disable iff (rst_i)
  report_valid_o && !report_ready_i |=> report_valid_o && $stable(report_o));

// The FIFO never sends more entries than the queue can hold.
assert property (@(posedge clk_i) disable iff (rst_i)
  q_push |-> q_cnt < CW'(CREDITS));

endmodule

//--- csi2_rx_top.sv
`timescale 1ns/1ps

module csi2_rx_top
#(
  parameter int FIFO_DEPTH = 16,
  parameter int CREDITS    = 2
)
(
  input                          clk_i,
  input                          rst_i,
  input  csi2_pkg::lane_word_t   lane_i,
  output csi2_pkg::line_report_t report_o,
  output logic                   report_valid_o,
  input                          report_ready_i,
  output csi2_pkg::frame_num_t   frame_num_o,
  output logic                   in_frame_o,
  output logic                   overflow_o
);

import csi2_pkg::*;

hdr_word_t  hdr;
pkt_entry_t hnd_entry;
logic       hnd_push;
pkt_entry_t fifo_entry;
logic       fifo_send;
logic       credit;

csi2_header_ecc u_ecc
(
  .clk_i  ( clk_i  ),
  .rst_i  ( rst_i  ),
  .lane_i ( lane_i ),
  .hdr_o  ( hdr    )
);

csi2_pkt_handler u_handler
(
  .clk_i   ( clk_i     ),
  .rst_i   ( rst_i     ),
  .hdr_i   ( hdr       ),
  .entry_o ( hnd_entry ),
  .push_o  ( hnd_push  )
);

csi2_payload_fifo #(
  .FIFO_DEPTH ( FIFO_DEPTH ),
  .CREDITS    ( CREDITS    )
) u_fifo (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .push_i     ( hnd_push   ),
  .entry_i    ( hnd_entry  ),
  .send_o     ( fifo_send  ),
  .entry_o    ( fifo_entry ),
  .credit_i   ( credit     ),
  .overflow_o ( overflow_o )
);

csi2_line_checker #(
  .CREDITS ( CREDITS )
) u_checker (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .send_i         ( fifo_send      ),
  .entry_i        ( fifo_entry     ),
  .credit_o       ( credit         ),
  .report_o       ( report_o       ),
  .report_valid_o ( report_valid_o ),
  .report_ready_i ( report_ready_i ),
  .frame_num_o    ( frame_num_o    ),
  .in_frame_o     ( in_frame_o     )
);

endmodule

//--- tb_csi2_checks.svh
`ifndef TB_CSI2_CHECKS_SVH
`define TB_CSI2_CHECKS_SVH

// Header ECC parity bits, one data mask per parity bit.
function automatic logic [5 : 0] ecc_of(input logic [23 : 0] d);
  logic [5 : 0] p;
  p[0] = ^(d & 24'hf12cb7);
  p[1] = ^(d & 24'hf2555b);
  p[2] = ^(d & 24'h749a6d);
  p[3] = ^(d & 24'hb8e38e);
  p[4] = ^(d & 24'hdf03f0);
  p[5] = ^(d & 24'heffc00);
  return p;
endfunction

// One byte of the reflected CRC-16, taken one bit at a time from bit 0 up.
function automatic crc_t crc_step(input crc_t crc, input logic [7 : 0] b);
  crc_t c;
  logic fb;
  c = crc;
  for (int k = 0; k < 8; k++)
    begin
      fb = c[0] ^ b[k];
      c  = c >> 1;
      if (fb)
        c = c ^ 16'h8408;
    end
  return c;
endfunction

function automatic logic [31 : 0] lfsr_next(input logic [31 : 0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic check_report(input line_report_t got, input line_report_t exp);
  if (got !== exp)
    begin
      $display("ERROR report_o got 0x%h expected 0x%h", got, exp);
      err_cnt++;
    end
endtask

task automatic check_frame(input frame_num_t got, input frame_num_t exp);
  if (got !== exp)
    begin
      $display("ERROR frame_num_o got 0x%h expected 0x%h", got, exp);
      err_cnt++;
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string name);
  if (got !== exp)
    begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
endtask

`endif

//--- tb_csi2_rx_top.sv
`timescale 1ns/1ps

module tb_csi2_rx_top;

import csi2_pkg::*;

localparam int FIFO_DEPTH = 16;
localparam int CREDITS    = 2;
localparam int MAX_CASES  = 64;
localparam int TIMEOUT    = 5000;

typedef struct packed
{
  logic [7 : 0]  dt;
  logic [7 : 0]  vc;
  logic [15 : 0] wc;
  logic [7 : 0]  base;
  logic [31 : 0] hdr_mask;
  logic [15 : 0] bad_idx;
  logic [7 : 0]  bad_mask;
  logic [7 : 0]  code;
} case_t;

logic           clk;
logic           rst;
lane_word_t     lane;
line_report_t   report;
logic           report_valid;
logic           report_ready;
frame_num_t     frame_num;
logic           in_frame;
logic           overflow;

logic [103 : 0] case_mem [MAX_CASES];
line_report_t   exp_q [$];
int             exp_id_q [$];
int             err_cnt;
int             pass_cnt;
int             fail_cnt;
logic           timed_out;
logic           hold_ready;
logic [31 : 0]  lfsr;
frame_num_t     model_frame;
logic           model_in_frame;

`include "tb_csi2_checks.svh"

csi2_rx_top #(
  .FIFO_DEPTH ( FIFO_DEPTH ),
  .CREDITS    ( CREDITS    )
) u_csi2_rx_top (
  .clk_i          ( clk          ),
  .rst_i          ( rst          ),
  .lane_i         ( lane         ),
  .report_o       ( report       ),
  .report_valid_o ( report_valid ),
  .report_ready_i ( report_ready ),
  .frame_num_o    ( frame_num    ),
  .in_frame_o     ( in_frame     ),
  .overflow_o     ( overflow     )
);

initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

always @(posedge clk)
  begin : ready_gen
    logic b0;
    logic b1;
    b0   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    report_ready <= !hold_ready && (b0 || b1);  // Stalls about one cycle in four.
  end

task automatic finish_run();
  $display("Summary: %0d cases passed, %0d cases failed, %0d errors",
           pass_cnt, fail_cnt, err_cnt);
  if (err_cnt == 0 && fail_cnt == 0 && !timed_out)
    $display("Test completed successfully");
  else
    $display("Test failed");
  $finish;
endtask

task automatic timeout_exit(input string what);
  $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
  timed_out = 1'b1;
  finish_run();
endtask

task automatic finish_case(input int id, input string what, input int errs_before);
  if (err_cnt == errs_before)
    begin
      pass_cnt++;
      $display("case %0d %s: pass", id, what);
    end
  else
    begin
      fail_cnt++;
      $display("case %0d %s: FAIL", id, what);
    end
endtask

task automatic drive_word(input word_t w);
  @(posedge clk);
  lane <= '{valid: 1'b1, data: w};
endtask

task automatic drive_idle();
  @(posedge clk);
  lane <= '0;
endtask

function automatic word_t make_header(input vc_t vc, input dt_t dt, input wc_t wc);
  logic [23 : 0] d;
  d = {wc, vc, dt};
  return {2'b00, ecc_of(d), d};
endfunction

task automatic wait_in_frame(input logic want);
  int n;
  n = 0;
  while (in_frame !== want && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
  if (in_frame !== want)
    timeout_exit("in_frame_o to change");
endtask

task automatic wait_reports_done();
  int n;
  n = 0;
  while (exp_q.size() > 0 && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
  if (exp_q.size() > 0)
    timeout_exit("the outstanding line reports");
endtask

task automatic run_short(input int id, input case_t c);
  int errs;
  errs = err_cnt;
  drive_word(make_header(c.vc[1 : 0], c.dt[5 : 0], c.wc) ^ c.hdr_mask);
  drive_idle();
  if (c.dt[5 : 0] == DT_FRAME_START)
    begin
      model_frame    = c.wc;
      model_in_frame = 1'b1;
    end
  else if (c.dt[5 : 0] == DT_FRAME_END)
    model_in_frame = 1'b0;
  wait_in_frame(model_in_frame);
  check_frame(frame_num, model_frame);
  check_flag(in_frame, model_in_frame, "in_frame_o");
  finish_case(id, "short packet", errs);
endtask

task automatic run_long(input int id, input case_t c, input logic expect_report);
  logic [7 : 0] pkt [$];
  word_t        hdr;
  word_t        bad_hdr;
  crc_t         crc_good;
  crc_t         crc_bad;
  line_report_t exp;
  hdr      = make_header(c.vc[1 : 0], c.dt[5 : 0], c.wc);
  bad_hdr  = hdr ^ c.hdr_mask;
  crc_good = 16'hffff;
  for (int k = 0; k < c.wc; k++)
    begin
      pkt.push_back(c.base + 8'(k));
      crc_good = crc_step(crc_good, pkt[k]);
    end
  if (c.bad_mask != 8'h00)
    pkt[c.bad_idx] = pkt[c.bad_idx] ^ c.bad_mask;
  crc_bad = 16'hffff;
  for (int k = 0; k < c.wc; k++)
    crc_bad = crc_step(crc_bad, pkt[k]);
  pkt.push_back(crc_good[7 : 0]);                 // Footer goes low byte first.
  pkt.push_back(crc_good[15 : 8]);
  while (pkt.size() % 4 != 0)
    pkt.push_back(8'h00);
  exp.frame_num = model_frame;
  if (c.code == 8'h03)
    begin
      exp.vc       = bad_hdr[7 : 6];                // An abort reports the header as received.
      exp.dt       = bad_hdr[5 : 0];
      exp.word_cnt = bad_hdr[23 : 8];
      exp.crc_rx   = '0;
      exp.crc_calc = '0;
      exp.crc_ok   = 1'b0;
      exp.aborted  = 1'b1;
    end
  else
    begin
      exp.vc       = c.vc[1 : 0];
      exp.dt       = c.dt[5 : 0];
      exp.word_cnt = c.wc;
      exp.crc_rx   = crc_good;
      exp.crc_calc = crc_bad;
      exp.crc_ok   = c.code == 8'h01;
      exp.aborted  = 1'b0;
    end
  if (expect_report)
    begin
      exp_q.push_back(exp);
      exp_id_q.push_back(id);
    end
  drive_word(bad_hdr);
  for (int k = 0; k < pkt.size(); k += 4)
    drive_word({pkt[k+3], pkt[k+2], pkt[k+1], pkt[k]});
  drive_idle();
endtask

task automatic run_overflow(input int id, input case_t c);
  int errs;
  int n;
  wait_reports_done();
  errs = err_cnt;
  check_flag(overflow, 1'b0, "overflow_o");
  hold_ready = 1'b1;
  run_long(id, c, 1'b0);                          // Its report stays pending and blocks the checker.
  run_long(id, c, 1'b0);
  n = 0;
  while (!overflow && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
  if (!overflow)
    timeout_exit("overflow_o to rise");
  check_flag(overflow, 1'b1, "overflow_o");
  finish_case(id, "overflow", errs);
endtask

initial
  begin : monitor
    line_report_t exp;
    int           id;
    int           errs;
    int           idle;
    idle = 0;
    forever
      begin
        @(negedge clk);
        if (report_valid && report_ready)
          begin
            idle = 0;
            if (exp_q.size() == 0)
              begin
                $display("A line report arrived that no packet should have produced: 0x%h",
                         report);
                err_cnt++;
              end
            else
              begin
                exp  = exp_q.pop_front();
                id   = exp_id_q.pop_front();
                errs = err_cnt;
                check_report(report, exp);
                finish_case(id, "line report", errs);
              end
          end
        else if (exp_q.size() > 0 && !hold_ready)
          begin
            idle++;
            if (idle > TIMEOUT)
              timeout_exit("a line report");
          end
        else
          idle = 0;
      end
  end

initial
  begin : main
    case_t c;
    int    i;
    rst            = 1'b1;
    lane           = '0;
    report_ready   = 1'b0;
    hold_ready     = 1'b0;
    lfsr           = 32'hf9cc;
    err_cnt        = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    timed_out      = 1'b0;
    model_frame    = '0;
    model_in_frame = 1'b0;
    for (int k = 0; k < MAX_CASES; k++)
      case_mem[k] = '1;
    $readmemh("csi2_rx_cases.txt", case_mem);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag(report_valid, 1'b0, "report_valid_o");
    check_flag(overflow, 1'b0, "overflow_o");
    check_frame(frame_num, 16'h0000);
    i = 0;
    c = case_t'(case_mem[0]);
    while (c.code != 8'hff && i < MAX_CASES)
      begin
        if (c.code == 8'h04)
          run_overflow(i, c);
        else if (c.dt[5 : 0] <= DT_SHORT_MAX)
          run_short(i, c);
        else
          run_long(i, c, 1'b1);
        i++;
        if (i < MAX_CASES)
          c = case_t'(case_mem[i]);
      end
    wait_reports_done();
    finish_run();
  end

endmodule

//--- csi2_rx_cases.txt
// dt_vc_wc_base_hdrmask_badidx_badmask_code, all hex; payload bytes count up from base.
// code: 00 short packet, 01 CRC good, 02 CRC bad, 03 aborted, 04 overflow, ff end of list.
00_00_0001_00_00000000_0000_00_00  // Frame start, frame 1.
2a_00_0010_10_00000000_0000_00_01
2a_01_000d_20_00000000_0000_00_01  // Last word has three bytes.
2b_02_000e_30_00000000_0000_00_01
2a_00_0001_40_00000000_0000_00_01
24_03_000f_50_00000000_0000_00_01  // Last word has one byte.
2a_00_0020_60_00000000_0005_80_02
1e_01_0011_70_00000000_0010_01_02
2a_00_0018_80_00000008_0000_00_01  // Single-bit error in dt.
2b_02_0009_90_00001000_0000_00_01  // Single-bit error in wc.
2a_01_0007_a0_04000000_0000_00_01  // Single-bit error in the ECC byte.
2a_00_0010_b0_00000300_0000_00_03
24_02_0020_c0_00100001_0000_00_03
01_00_0000_00_00000000_0000_00_00  // Frame end.
00_00_0002_00_00000000_0000_00_00  // Frame start, frame 2.
2a_00_0040_d0_00000000_0000_00_01
2b_01_003f_e0_00000080_0000_00_01  // Single-bit error in vc.
2a_03_0021_f0_00000000_0000_00_01
2a_02_0006_05_00000000_0003_ff_02
01_00_0000_00_00000000_0000_00_00
2a_00_00c8_11_00000000_0000_00_04  // Sent twice with the report port held.
ff_ff_ffff_ff_ffffffff_ffff_ff_ff

//--- compile.f
+incdir+.
csi2_pkg.sv
csi2_header_ecc.sv
csi2_pkt_handler.sv
csi2_payload_fifo.sv
csi2_line_checker.sv
csi2_rx_top.sv
tb_csi2_rx_top.sv

//--- Bender.yml
package:
  name: csi2_rx

sources:
  - csi2_pkg.sv
  - csi2_header_ecc.sv
  - csi2_pkt_handler.sv
  - csi2_payload_fifo.sv
  - csi2_line_checker.sv
  - csi2_rx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csi2_rx_top.sv
